// File: logic/fetch_ctrl.sv
// Fetch control FSM: memory request sequencing, stale response drop, queue write gating
`default_nettype none

module fetch_ctrl
    import fetch_pkg::*;
(
    input  logic clk,
    input  logic arst_n,
    input  logic flush,
    input  logic iq_full,
    input  logic imem_resp,
    output logic imem_read,
    output logic iq_write,
    output logic pc_advance
);

    fetch_state_e state;
    fetch_state_e state_next;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        imem_read  = 1'b0;
        iq_write   = 1'b0;
        pc_advance = 1'b0;

        unique case (state)
            st_idle: begin
                state_next = st_request;
            end

            st_request: begin
                // No request with a PC that is about to be replaced
                if (!flush && !iq_full) begin
                    imem_read  = 1'b1;
                    state_next = st_wait;
                end
            end

            st_wait: begin
                if (flush) begin
                    // A response in this very cycle is already stale
                    if (imem_resp) begin
                        state_next = st_request;
                    end else begin
                        state_next = st_discard;
                    end
                end else if (imem_resp) begin
                    iq_write   = 1'b1;
                    pc_advance = 1'b1;
                    state_next = st_request;
                end
            end

            st_discard: begin
                // Drop the old word, then restart at the redirect target
                if (imem_resp) begin
                    state_next = st_request;
                end
            end

            default: begin
                state_next = st_idle;
            end
        endcase
    end

endmodule : fetch_ctrl

`default_nettype wire

// File: logic/fetch_pkg.sv
// Instruction queue entry struct, fetch state enum, queue depth and pointer widths
`default_nettype none

package fetch_pkg;

    import rv32i_pkg::*;

    // Queue depth and derived widths
    localparam int iq_entries = 8;
    localparam int iq_ptr_w   = $clog2(iq_entries);
    localparam int iq_cnt_w   = $clog2(iq_entries + 1);

    // One queue entry as seen by the decoder
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] next_pc;
        logic [xlen-1:0] instr;
    } i_queue_data_t;

    // Fetch control states
    typedef enum logic [1:0] {
        st_idle    = 2'd0,
        st_request = 2'd1,
        st_wait    = 2'd2,
        // Waiting for a response that belongs to a flushed path
        st_discard = 2'd3
    } fetch_state_e;

endpackage : fetch_pkg

`default_nettype wire

// File: logic/fetch_unit.sv
// Fetch front end top: control FSM, PC generator, predecoder and instruction queue
`default_nettype none

module fetch_unit
    import rv32i_pkg::*;
    import fetch_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  logic            flush,
    input  logic            iq_read,
    input  logic            imem_resp,
    input  logic [xlen-1:0] redirect_pc,
    input  logic [xlen-1:0] imem_rdata,
    output logic            imem_read,
    output logic [xlen-1:0] imem_addr,
    output i_queue_data_t   iq_data,
    output logic            iq_empty,
    output logic            iq_full
);

    logic            iq_write;
    logic            pc_advance;
    logic [xlen-1:0] fetch_pc;
    logic [xlen-1:0] pred_next_pc;
    i_queue_data_t   iq_wdata;

    assign imem_addr = fetch_pc;
    assign iq_wdata  = '{pc: fetch_pc, next_pc: pred_next_pc, instr: imem_rdata};

    fetch_ctrl i_ctrl (
        .clk        (clk),
        .arst_n     (arst_n),
        .flush      (flush),
        .iq_full    (iq_full),
        .imem_resp  (imem_resp),
        .imem_read  (imem_read),
        .iq_write   (iq_write),
        .pc_advance (pc_advance)
    );

    pc_gen i_pc_gen (
        .clk          (clk),
        .arst_n       (arst_n),
        .flush        (flush),
        .pc_advance   (pc_advance),
        .redirect_pc  (redirect_pc),
        .pred_next_pc (pred_next_pc),
        .fetch_pc     (fetch_pc)
    );

    // Opcode class only steers the prediction inside the predecoder
    predecode i_predecode (
        .instr        (imem_rdata),
        .pc           (fetch_pc),
        .opcode       (),
        .pred_next_pc (pred_next_pc)
    );

    i_queue i_iq (
        .clk      (clk),
        .arst_n   (arst_n),
        .flush    (flush),
        .read     (iq_read),
        .write    (iq_write),
        .data_in  (iq_wdata),
        .data_out (iq_data),
        .empty    (iq_empty),
        .full     (iq_full)
    );

endmodule : fetch_unit

`default_nettype wire

// File: logic/i_queue.sv
// Circular instruction queue with registered head, occupancy counter and full/empty flags
`default_nettype none

module i_queue
    import fetch_pkg::*;
(
    input  logic          clk,
    input  logic          arst_n,
    input  logic          flush,
    input  logic          read,
    input  logic          write,
    input  i_queue_data_t data_in,
    output i_queue_data_t data_out,
    output logic          empty,
    output logic          full
);

    i_queue_data_t mem [iq_entries];

    logic [iq_ptr_w-1:0] head_ptr;
    logic [iq_ptr_w-1:0] tail_ptr;
    logic [iq_ptr_w-1:0] head_ptr_inc;
    logic [iq_cnt_w-1:0] count;
    logic                do_read;
    logic                do_write;

    assign empty = (count == '0);
    assign full  = (count == iq_cnt_w'(iq_entries));

    // Pops on empty are ignored, pushes only with room left
    assign do_read      = read && !empty;
    assign do_write     = write && (!full || do_read);
    assign head_ptr_inc = head_ptr + 1'b1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else if (flush) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (do_read) begin
                head_ptr <= head_ptr_inc;
            end
            if (do_write) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            unique case ({do_read, do_write})
                2'b01:   count <= count + 1'b1;
                2'b10:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[tail_ptr] <= data_in;
        end
        if (do_read) begin
            // Last stored entry leaves, so the new word is the next head
            if (count == iq_cnt_w'(1)) begin
                if (do_write) begin
                    data_out <= data_in;
                end
            end else begin
                data_out <= mem[head_ptr_inc];
            end
        end else if (do_write && empty) begin
            // Bypass into the head register
            data_out <= data_in;
        end
    end

endmodule : i_queue

`default_nettype wire

// File: logic/pc_gen.sv
// Fetch PC register with redirect, predicted and sequential next-PC selection
`default_nettype none

module pc_gen
    import rv32i_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  logic            flush,
    input  logic            pc_advance,
    input  logic [xlen-1:0] redirect_pc,
    input  logic [xlen-1:0] pred_next_pc,
    output logic [xlen-1:0] fetch_pc
);

    // Redirect wins over the predicted path
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch_pc <= reset_vector;
        end else if (flush) begin
            fetch_pc <= redirect_pc;
        end else if (pc_advance) begin
            // Sequential or JAL target, chosen by the predecoder
            fetch_pc <= pred_next_pc;
        end
    end

endmodule : pc_gen

`default_nettype wire

// File: logic/predecode.sv
// Opcode classification and JAL target prediction for a fetched word
`default_nettype none

module predecode
    import rv32i_pkg::*;
(
    input  logic [xlen-1:0] instr,
    input  logic [xlen-1:0] pc,
    output rv32i_opcode_e   opcode,
    output logic [xlen-1:0] pred_next_pc
);

    logic [imm_j_w-1:0] imm_j;
    logic [xlen-1:0]    imm_j_sext;

    always_comb begin
        unique case (instr[opcode_w-1:0])
            op_lui,
            op_auipc,
            op_jal,
            op_jalr,
            op_branch,
            op_load,
            op_store,
            op_imm,
            op_reg,
            op_system: opcode = rv32i_opcode_e'(instr[opcode_w-1:0]);
            default:   opcode = op_other;
        endcase
    end

    // J-type immediate, bit 0 always zero
    assign imm_j      = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_j_sext = {{(xlen - imm_j_w){imm_j[imm_j_w-1]}}, imm_j};

    // Branches and JALR fall through
    assign pred_next_pc = (opcode == op_jal) ? pc + imm_j_sext : pc + 32'd4;

endmodule : predecode

`default_nettype wire

// File: logic/rv32i_pkg.sv
// RV32I major opcode enum, instruction field widths and the reset vector
`default_nettype none

package rv32i_pkg;

    // Data and address width
    localparam int xlen = 32;

    // Instruction field widths
    localparam int opcode_w = 7;
    localparam int imm_j_w  = 21;

    // First fetch address out of reset
    localparam logic [xlen-1:0] reset_vector = 32'h0000_0100;

    // Major opcodes, bits [6:0] of the instruction
    typedef enum logic [opcode_w-1:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_system = 7'b1110011,
        // Anything not listed above
        op_other  = 7'b1111111
    } rv32i_opcode_e;

endpackage : rv32i_pkg

`default_nettype wire

// File: tb.f
logic/rv32i_pkg.sv
logic/fetch_pkg.sv
logic/fetch_ctrl.sv
logic/pc_gen.sv
logic/predecode.sv
logic/i_queue.sv
logic/fetch_unit.sv
verif/fetch_checker.sv
verif/fetch_tb.sv

// File: verif/fetch_checker.sv
// Reference fetch model, memory image function, popped entry comparison and error counts
`default_nettype none

module fetch_checker
    import rv32i_pkg::*;
    import fetch_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  logic            flush,
    input  logic [xlen-1:0] redirect_pc,
    input  logic            iq_read,
    input  i_queue_data_t   iq_data,
    input  logic            iq_empty,
    input  logic            iq_full,
    input  logic            imem_read,
    input  logic [xlen-1:0] imem_addr,
    input  logic [xlen-1:0] image_addr,
    output logic [xlen-1:0] image_data,
    output int              err_count,
    output int              pop_count
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [xlen-1:0] exp_pc;
    logic            first_req_seen;

    // JAL x0 +16 in word 5 of every eight, ADDI x1, x0, addr[11:0] elsewhere
    function automatic logic [xlen-1:0] image_word(input logic [xlen-1:0] addr);
        if (addr[4:2] == 3'd5) begin
            return {1'b0, 10'd8, 1'b0, 8'd0, 5'd0, 7'b1101111};
        end
        return {addr[11:0], 5'd0, 3'b000, 5'd1, 7'b0010011};
    endfunction

    function automatic logic [xlen-1:0] follow_pc(input logic [xlen-1:0] pc);
        return (pc[4:2] == 3'd5) ? pc + 32'd16 : pc + 32'd4;
    endfunction

    task automatic compare_word(input string name, input logic [xlen-1:0] exp_v,
                                input logic [xlen-1:0] got_v);
        if (got_v !== exp_v) begin
            $display("ERR t=%0t %s exp=%h got=%h", $time, name, exp_v, got_v);
            err_count++;
        end
    endtask

    assign image_data = image_word(image_addr);

    initial begin
        err_count = 0;
        pop_count = 0;
    end

    // Output levels at reset release, before the first fetch edge
    always @(posedge arst_n) begin
        compare_word("iq_empty", 1, iq_empty);
        compare_word("iq_full", 0, iq_full);
        compare_word("imem_read", 0, imem_read);
    end

    always @(posedge clk) begin
        if (!arst_n) begin
            exp_pc         = reset_vector;
            first_req_seen = 1'b0;
        end else begin
            if (imem_read && !first_req_seen) begin
                first_req_seen = 1'b1;
                compare_word("imem_addr", reset_vector, imem_addr);
            end
            if (imem_read && iq_full) begin
                $display("ERR t=%0t imem_read exp=0 got=1", $time);
                err_count++;
            end
            // Flush wins over a pop in the same cycle
            if (flush) begin
                exp_pc = redirect_pc;
            end else if (iq_read && !iq_empty) begin
                compare_word("iq_data.pc", exp_pc, iq_data.pc);
                compare_word("iq_data.next_pc", follow_pc(exp_pc), iq_data.next_pc);
                compare_word("iq_data.instr", image_word(exp_pc), iq_data.instr);
                pop_count++;
                exp_pc = follow_pc(exp_pc);
            end
        end
    end

endmodule : fetch_checker

`default_nettype wire

// File: verif/fetch_tb.sv
// Fetch unit testbench: clock, reset, memory model, stimulus table and timeout
`default_nettype none

module fetch_tb
    import rv32i_pkg::*;
    import fetch_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int         clk_period = 40;
    localparam int         n_rows     = 9;
    localparam int         margin     = 200;
    localparam logic [1:0] rd_always  = 2'd0;
    localparam logic [1:0] rd_never   = 2'd1;
    localparam logic [1:0] rd_random  = 2'd2;

    typedef struct packed {
        logic [3:0]      latency;
        logic [1:0]      read_mode;
        logic [15:0]     cycles;
        logic            do_flush;
        logic [xlen-1:0] target;
    } row_t;

    logic            clk;
    logic            arst_n;
    logic            flush;
    logic            iq_read;
    logic            imem_resp;
    logic [xlen-1:0] redirect_pc;
    logic [xlen-1:0] imem_rdata;
    logic            imem_read;
    logic [xlen-1:0] imem_addr;
    i_queue_data_t   iq_data;
    logic            iq_empty;
    logic            iq_full;

    row_t            rows [n_rows];
    int              seed        = 43;
    int              cycle_count = 0;
    int              cycle_limit = margin;
    int              tb_errors   = 0;
    int              chk_errors;
    int              pop_count;
    int              cur_latency;
    logic            mem_busy;
    int              mem_wait;
    logic [xlen-1:0] mem_addr;
    logic [xlen-1:0] image_data;

    fetch_unit i_dut (
        .clk (clk), .arst_n (arst_n), .flush (flush), .iq_read (iq_read),
        .imem_resp (imem_resp), .redirect_pc (redirect_pc), .imem_rdata (imem_rdata),
        .imem_read (imem_read), .imem_addr (imem_addr), .iq_data (iq_data),
        .iq_empty (iq_empty), .iq_full (iq_full)
    );

    fetch_checker i_check (
        .clk (clk), .arst_n (arst_n), .flush (flush), .redirect_pc (redirect_pc),
        .iq_read (iq_read), .iq_data (iq_data), .iq_empty (iq_empty), .iq_full (iq_full),
        .imem_read (imem_read), .imem_addr (imem_addr), .image_addr (mem_addr),
        .image_data (image_data), .err_count (chk_errors), .pop_count (pop_count)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Run length guard, counted from reset release
    initial begin : watchdog
        @(posedge arst_n);
        while (cycle_count <= cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run exceeded %0d cycles", cycle_limit);
        $display("Simulation FAILED");
        $finish;
    end

    // One clock: sample requests on the edge, answer and drive 2 ns later
    task automatic step_cycle(input logic [1:0] read_mode);
        int rnd;
        @(posedge clk);
        if (imem_read) begin
            mem_busy = 1'b1;
            mem_addr = imem_addr;
            mem_wait = cur_latency;
        end
        #2;
        imem_resp  = 1'b0;
        imem_rdata = '0;
        if (mem_busy) begin
            mem_wait--;
            if (mem_wait == 0) begin
                imem_resp  = 1'b1;
                imem_rdata = image_data;
                mem_busy   = 1'b0;
            end
        end
        rnd = $random(seed);
        case (read_mode)
            rd_always: iq_read = 1'b1;
            rd_never:  iq_read = 1'b0;
            default:   iq_read = rnd[0];
        endcase
    endtask

    task automatic load_table();
        rows[0] = '{4'd1, rd_always, 16'd60, 1'b0, 32'h0};
        rows[1] = '{4'd2, rd_never,  16'd60, 1'b0, 32'h0};
        rows[2] = '{4'd3, rd_always, 16'd60, 1'b0, 32'h0};
        rows[3] = '{4'd4, rd_always, 16'd40, 1'b1, 32'h0000_0200};
        rows[4] = '{4'd1, rd_random, 16'd80, 1'b0, 32'h0};
        rows[5] = '{4'd2, rd_random, 16'd80, 1'b1, 32'h0000_0340};
        rows[6] = '{4'd3, rd_random, 16'd80, 1'b0, 32'h0};
        rows[7] = '{4'd4, rd_random, 16'd80, 1'b1, 32'h0000_01f0};
        rows[8] = '{4'd1, rd_always, 16'd60, 1'b0, 32'h0};
    endtask

    initial begin : main
        row_t row;
        arst_n      = 1'b0;
        flush       = 1'b0;
        iq_read     = 1'b0;
        imem_resp   = 1'b0;
        redirect_pc = '0;
        imem_rdata  = '0;
        mem_busy    = 1'b0;
        mem_wait    = 0;
        mem_addr    = '0;
        cur_latency = 1;
        load_table();
        for (int r = 0; r < n_rows; r++) begin
            cycle_limit += rows[r].cycles;
        end
        repeat (8) @(posedge clk);
        #2;
        arst_n = 1'b1;
        for (int r = 0; r < n_rows; r++) begin
            row         = rows[r];
            cur_latency = row.latency;
            if (row.do_flush) begin
                // Flush only while a response is still outstanding
                while (!mem_busy) begin
                    step_cycle(row.read_mode);
                end
                flush       = 1'b1;
                redirect_pc = row.target;
                step_cycle(row.read_mode);
                flush = 1'b0;
            end
            repeat (row.cycles) step_cycle(row.read_mode);
            if (row.read_mode == rd_never && !iq_full) begin
                $display("Queue did not fill while reads were stopped");
                tb_errors++;
            end
        end
        if (pop_count == 0) begin
            $display("No queue entries were popped during the run");
            tb_errors++;
        end
        $display("Summary: %0d entries checked, %0d checker errors, %0d testbench errors",
                 pop_count, chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule : fetch_tb

`default_nettype wire
